// ==== logic/bpu_pkg.sv ====
// shared widths, jump-type codes and counter constants for the branch predictor and its testbench
`default_nettype none

package bpu_pkg;

  // address and instruction word widths
  localparam int pc_width = 32;
  localparam int word_width = pc_width - 2;

  // four instructions per fetch group
  localparam int group_slots = 4;
  localparam int slot_bits = 2;

  // 2-bit saturating prediction counter
  localparam int ctr_width = 2;
  localparam logic [ctr_width-1:0] ctr_alloc = 2'd2;
  localparam logic [ctr_width-1:0] ctr_taken_min = 2'd2;

  // jump-type codes stored with each table entry
  localparam int jt_width = 2;
  localparam logic [jt_width-1:0] jt_branch = 2'd0;
  // call pushes pc + 4 on the return stack
  localparam logic [jt_width-1:0] jt_call = 2'd1;
  // return takes its target from the stack top
  localparam logic [jt_width-1:0] jt_return = 2'd2;
  localparam logic [jt_width-1:0] jt_jump = 2'd3;

endpackage

`default_nettype wire

// ==== logic/branch_predictor.sv ====
// branch predictor top, wiring the target table and return stack into the fetch group selector
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
  parameter int table_idx_bits = 7,
  parameter int ras_depth = 8
) (
  input  wire                              clk,
  input  wire                              reset,
  input  wire  [bpu_pkg::pc_width-1:0]     pc,
  input  wire                              fetch_valid,
  output logic [bpu_pkg::pc_width-1:0]     next_pc,
  output logic [bpu_pkg::group_slots-1:0]  pc_valid,
  output logic [bpu_pkg::group_slots-1:0]  pc_is_jump,
  input  wire                              res0_valid,
  input  wire  [bpu_pkg::pc_width-1:0]     res0_pc,
  input  wire                              res0_taken,
  input  wire  [bpu_pkg::pc_width-1:0]     res0_target,
  input  wire  [bpu_pkg::jt_width-1:0]     res0_type,
  input  wire                              res1_valid,
  input  wire  [bpu_pkg::pc_width-1:0]     res1_pc,
  input  wire                              res1_taken,
  input  wire  [bpu_pkg::pc_width-1:0]     res1_target,
  input  wire  [bpu_pkg::jt_width-1:0]     res1_type
);

  logic [bpu_pkg::group_slots-1:0]                          slot_hit;
  logic [bpu_pkg::group_slots-1:0][bpu_pkg::jt_width-1:0]   slot_type;
  logic [bpu_pkg::group_slots-1:0][bpu_pkg::word_width-1:0] slot_target;
  logic [bpu_pkg::word_width-1:0] ras_top;
  logic ras_empty;
  logic ras_pop;

  branch_target_table #(
    .table_idx_bits(table_idx_bits)
  ) u_table (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .res0_valid (res0_valid),
    .res0_pc    (res0_pc),
    .res0_taken (res0_taken),
    .res0_target(res0_target),
    .res0_type  (res0_type),
    .res1_valid (res1_valid),
    .res1_pc    (res1_pc),
    .res1_taken (res1_taken),
    .res1_target(res1_target),
    .res1_type  (res1_type),
    .slot_hit   (slot_hit),
    .slot_type  (slot_type),
    .slot_target(slot_target)
  );

  return_stack #(
    .ras_depth(ras_depth)
  ) u_ras (
    .clk       (clk),
    .reset     (reset),
    .ras_pop   (ras_pop),
    .res0_valid(res0_valid),
    .res0_taken(res0_taken),
    .res0_type (res0_type),
    .res0_pc   (res0_pc),
    .res1_valid(res1_valid),
    .res1_taken(res1_taken),
    .res1_type (res1_type),
    .res1_pc   (res1_pc),
    .ras_top   (ras_top),
    .ras_empty (ras_empty)
  );

  fetch_group_select u_select (
    .pc         (pc),
    .fetch_valid(fetch_valid),
    .slot_hit   (slot_hit),
    .slot_type  (slot_type),
    .slot_target(slot_target),
    .ras_top    (ras_top),
    .ras_empty  (ras_empty),
    .next_pc    (next_pc),
    .pc_valid   (pc_valid),
    .pc_is_jump (pc_is_jump),
    .ras_pop    (ras_pop)
  );

endmodule

`default_nettype wire

// ==== logic/branch_target_table.sv ====
// direct-mapped target table with 2-bit counters, read for four fetch slots and trained by two resolve ports
`timescale 1ns/1ps
`default_nettype none

module branch_target_table #(
  parameter int table_idx_bits = 7
) (
  input  wire                              clk,
  input  wire                              reset,
  input  wire  [bpu_pkg::pc_width-1:0]     pc,
  input  wire                              res0_valid,
  input  wire  [bpu_pkg::pc_width-1:0]     res0_pc,
  input  wire                              res0_taken,
  input  wire  [bpu_pkg::pc_width-1:0]     res0_target,
  input  wire  [bpu_pkg::jt_width-1:0]     res0_type,
  input  wire                              res1_valid,
  input  wire  [bpu_pkg::pc_width-1:0]     res1_pc,
  input  wire                              res1_taken,
  input  wire  [bpu_pkg::pc_width-1:0]     res1_target,
  input  wire  [bpu_pkg::jt_width-1:0]     res1_type,
  output logic [bpu_pkg::group_slots-1:0]  slot_hit,
  output logic [bpu_pkg::group_slots-1:0][bpu_pkg::jt_width-1:0]   slot_type,
  output logic [bpu_pkg::group_slots-1:0][bpu_pkg::word_width-1:0] slot_target
);

  localparam int entries = 1 << table_idx_bits;
  localparam int tag_bits = bpu_pkg::word_width - table_idx_bits;

  logic [entries-1:0]               valid_q;
  logic [tag_bits-1:0]              tag_mem    [entries];
  logic [bpu_pkg::ctr_width-1:0]    ctr_mem    [entries];
  logic [bpu_pkg::jt_width-1:0]     type_mem   [entries];
  logic [bpu_pkg::word_width-1:0]   target_mem [entries];

  logic [tag_bits-1:0] lookup_tag;

  // resolve ports gathered into arrays, index 1 is res1
  logic [1:0]                             res_valid;
  logic [1:0]                             res_taken;
  logic [1:0][bpu_pkg::pc_width-1:0]      res_pc;
  logic [1:0][bpu_pkg::word_width-1:0]    res_word;
  logic [1:0][bpu_pkg::jt_width-1:0]      res_type;

  logic [1:0][table_idx_bits-1:0]         wr_idx;
  logic [1:0][tag_bits-1:0]               wr_tag;
  logic [1:0][bpu_pkg::ctr_width-1:0]     wr_ctr;
  logic [1:0]                             wr_hit;
  logic [1:0]                             wr_en;
  logic [1:0]                             wr_do;

  assign lookup_tag = pc[bpu_pkg::pc_width-1 -: tag_bits];

  // lookup: slot s reads the group index with its low two bits set to s
  for (genvar s = 0; s < bpu_pkg::group_slots; s++) begin : g_slot
    localparam logic [bpu_pkg::slot_bits-1:0] slot_id = s;
    logic [table_idx_bits-1:0] idx;

    assign idx = {pc[table_idx_bits+1:bpu_pkg::slot_bits+2], slot_id};
    assign slot_hit[s] = valid_q[idx] && (tag_mem[idx] == lookup_tag)
                         && (ctr_mem[idx] >= bpu_pkg::ctr_taken_min);
    assign slot_type[s] = type_mem[idx];
    assign slot_target[s] = target_mem[idx];
  end

  assign res_valid = {res1_valid, res0_valid};
  assign res_taken = {res1_taken, res0_taken};
  assign res_pc    = {res1_pc, res0_pc};
  assign res_type  = {res1_type, res0_type};
  assign res_word  = {res1_target[bpu_pkg::pc_width-1:2], res0_target[bpu_pkg::pc_width-1:2]};

  for (genvar p = 0; p < 2; p++) begin : g_port
    logic [bpu_pkg::ctr_width-1:0] cur_ctr;
    logic [bpu_pkg::ctr_width-1:0] ctr_up;
    logic [bpu_pkg::ctr_width-1:0] ctr_down;

    assign wr_idx[p] = res_pc[p][table_idx_bits+1:2];
    assign wr_tag[p] = res_pc[p][bpu_pkg::pc_width-1 -: tag_bits];
    assign wr_hit[p] = valid_q[wr_idx[p]] && (tag_mem[wr_idx[p]] == wr_tag[p]);
    assign cur_ctr = ctr_mem[wr_idx[p]];
    assign ctr_up = (cur_ctr == '1) ? cur_ctr : cur_ctr + 1'b1;
    assign ctr_down = (cur_ctr == '0) ? cur_ctr : cur_ctr - 1'b1;

    // a taken miss allocates, any hit trains
    assign wr_en[p] = res_valid[p] && (wr_hit[p] || res_taken[p]);
    assign wr_ctr[p] = !wr_hit[p] ? bpu_pkg::ctr_alloc : (res_taken[p] ? ctr_up : ctr_down);
  end

  // res1 wins when both ports hit the same entry
  assign wr_do[1] = wr_en[1];
  assign wr_do[0] = wr_en[0] && !(wr_en[1] && (wr_idx[0] == wr_idx[1]));

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (wr_do[p]) begin
          valid_q[wr_idx[p]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (wr_do[p]) begin
        ctr_mem[wr_idx[p]] <= wr_ctr[p];
        // taken resolves refresh target and type
        if (res_taken[p]) begin
          tag_mem[wr_idx[p]] <= wr_tag[p];
          type_mem[wr_idx[p]] <= res_type[p];
          target_mem[wr_idx[p]] <= res_word[p];
        end
      end
    end
  end

  // execute stage only reports word-aligned targets
  a_target_aligned: assert property (@(posedge clk) disable iff (reset)
    (res0_valid |-> (res0_target[1:0] == 2'b00)) and (res1_valid |-> (res1_target[1:0] == 2'b00)))
    else $error("resolve target not word aligned");

endmodule

`default_nettype wire

// ==== logic/fetch_group_select.sv ====
// picks the first predicted-taken slot of the fetch group and forms next_pc and the slot masks
`timescale 1ns/1ps
`default_nettype none

module fetch_group_select (
  input  wire  [bpu_pkg::pc_width-1:0]     pc,
  input  wire                              fetch_valid,
  input  wire  [bpu_pkg::group_slots-1:0]  slot_hit,
  input  wire  [bpu_pkg::group_slots-1:0][bpu_pkg::jt_width-1:0]   slot_type,
  input  wire  [bpu_pkg::group_slots-1:0][bpu_pkg::word_width-1:0] slot_target,
  input  wire  [bpu_pkg::word_width-1:0]   ras_top,
  input  wire                              ras_empty,
  output logic [bpu_pkg::pc_width-1:0]     next_pc,
  output logic [bpu_pkg::group_slots-1:0]  pc_valid,
  output logic [bpu_pkg::group_slots-1:0]  pc_is_jump,
  output logic                             ras_pop
);

  localparam int group_lsb = bpu_pkg::slot_bits + 2;

  logic [bpu_pkg::slot_bits-1:0]   start_slot;
  logic [bpu_pkg::slot_bits-1:0]   sel_slot;
  logic [bpu_pkg::group_slots-1:0] start_mask;
  logic [bpu_pkg::group_slots-1:0] qualify;
  logic found;
  logic sel_is_return;

  assign start_slot = pc[group_lsb-1:2];
  assign start_mask = {bpu_pkg::group_slots{1'b1}} << start_slot;

  // returns only count while the stack has an address
  for (genvar s = 0; s < bpu_pkg::group_slots; s++) begin : g_qual
    assign qualify[s] = start_mask[s] && slot_hit[s]
                        && ((slot_type[s] != bpu_pkg::jt_return) || !ras_empty);
  end

  // lowest qualifying slot wins
  always_comb begin
    found = 1'b0;
    sel_slot = '0;
    for (int s = bpu_pkg::group_slots - 1; s >= 0; s--) begin
      if (qualify[s]) begin
        found = 1'b1;
        sel_slot = s[bpu_pkg::slot_bits-1:0];
      end
    end
  end

  assign sel_is_return = (slot_type[sel_slot] == bpu_pkg::jt_return);

  always_comb begin
    if (found) begin
      pc_is_jump = {{(bpu_pkg::group_slots - 1){1'b0}}, 1'b1} << sel_slot;
      // start slot through the jump slot
      pc_valid = start_mask
                 & ({bpu_pkg::group_slots{1'b1}} >> (bpu_pkg::group_slots - 1 - sel_slot));
      next_pc = sel_is_return ? {ras_top, 2'b00} : {slot_target[sel_slot], 2'b00};
    end else begin
      pc_is_jump = '0;
      pc_valid = start_mask;
      next_pc = {pc[bpu_pkg::pc_width-1:group_lsb] + 1'b1, {group_lsb{1'b0}}};
    end
  end

  assign ras_pop = fetch_valid && found && sel_is_return;

  // at most one jump, and it sits inside the valid slots
  always_comb begin
    a_jump_in_group: assert final ($onehot0(pc_is_jump) && ((pc_is_jump & ~pc_valid) == '0))
      else $error("bad jump slot mask %b with valid %b", pc_is_jump, pc_valid);
  end

endmodule

`default_nettype wire

// ==== logic/return_stack.sv ====
// circular return-address stack, pushed by resolved calls and popped by predicted returns
`timescale 1ns/1ps
`default_nettype none

module return_stack #(
  parameter int ras_depth = 8
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             ras_pop,
  input  wire                             res0_valid,
  input  wire                             res0_taken,
  input  wire  [bpu_pkg::jt_width-1:0]    res0_type,
  input  wire  [bpu_pkg::pc_width-1:0]    res0_pc,
  input  wire                             res1_valid,
  input  wire                             res1_taken,
  input  wire  [bpu_pkg::jt_width-1:0]    res1_type,
  input  wire  [bpu_pkg::pc_width-1:0]    res1_pc,
  output logic [bpu_pkg::word_width-1:0]  ras_top,
  output logic                            ras_empty
);

  localparam int ptr_bits = (ras_depth > 1) ? $clog2(ras_depth) : 1;
  localparam int cnt_bits = $clog2(ras_depth + 1);

  logic [bpu_pkg::word_width-1:0] ras_mem [ras_depth];

  logic [ptr_bits-1:0] top_q;
  logic [ptr_bits-1:0] top_pop;
  logic [ptr_bits-1:0] push0_ptr;
  logic [ptr_bits-1:0] push1_ptr;
  logic [cnt_bits-1:0] count_q;
  logic [cnt_bits-1:0] count_pop;
  logic [cnt_bits-1:0] count_push0;
  logic push0;
  logic push1;

  function automatic logic [ptr_bits-1:0] ptr_next(input logic [ptr_bits-1:0] ptr);
    return (ptr == ptr_bits'(ras_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  function automatic logic [ptr_bits-1:0] ptr_prev(input logic [ptr_bits-1:0] ptr);
    return (ptr == '0) ? ptr_bits'(ras_depth - 1) : ptr - 1'b1;
  endfunction

  // full stack keeps its count, the oldest entry gets overwritten
  function automatic logic [cnt_bits-1:0] cnt_inc(input logic [cnt_bits-1:0] cnt);
    return (cnt == cnt_bits'(ras_depth)) ? cnt : cnt + 1'b1;
  endfunction

  assign push0 = res0_valid && res0_taken && (res0_type == bpu_pkg::jt_call);
  assign push1 = res1_valid && res1_taken && (res1_type == bpu_pkg::jt_call);

  // pop first, then res0 push, then res1 push
  assign top_pop = ras_pop ? ptr_prev(top_q) : top_q;
  assign count_pop = ras_pop ? count_q - 1'b1 : count_q;
  assign push0_ptr = ptr_next(top_pop);
  assign push1_ptr = push0 ? ptr_next(push0_ptr) : push0_ptr;
  assign count_push0 = push0 ? cnt_inc(count_pop) : count_pop;

  always_ff @(posedge clk) begin
    if (reset) begin
      top_q <= '0;
      count_q <= '0;
    end else begin
      top_q <= push1 ? push1_ptr : (push0 ? push0_ptr : top_pop);
      count_q <= push1 ? cnt_inc(count_push0) : count_push0;
    end
  end

  // return address is the call pc plus one word
  always_ff @(posedge clk) begin
    if (push0) begin
      ras_mem[push0_ptr] <= res0_pc[bpu_pkg::pc_width-1:2] + 1'b1;
    end
    if (push1) begin
      ras_mem[push1_ptr] <= res1_pc[bpu_pkg::pc_width-1:2] + 1'b1;
    end
  end

  assign ras_top = ras_mem[top_q];
  assign ras_empty = (count_q == '0);

  // selector must not predict a return from an empty stack
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) ras_pop |-> !ras_empty)
    else $error("return stack popped while empty");

endmodule

`default_nettype wire

// ==== include/bp_vectors.svh ====
// stimulus and expected-result rows for the predictor testbench, one row per clock cycle
`ifndef BP_VECTORS_SVH
`define BP_VECTORS_SVH

// lookup outputs are checked against the row's own pc; resolves and pops
// land on the edge that ends the row, so they show from the next row on
typedef struct packed {
  logic [7:0]                       test_id;
  logic                             fetch_valid;
  logic [bpu_pkg::pc_width-1:0]     pc;
  logic [bpu_pkg::pc_width-1:0]     exp_next_pc;
  logic [bpu_pkg::group_slots-1:0]  exp_pc_valid;
  logic [bpu_pkg::group_slots-1:0]  exp_pc_is_jump;
  logic                             res0_valid;
  logic [bpu_pkg::pc_width-1:0]     res0_pc;
  logic                             res0_taken;
  logic [bpu_pkg::pc_width-1:0]     res0_target;
  logic [bpu_pkg::jt_width-1:0]     res0_type;
  logic                             res1_valid;
  logic [bpu_pkg::pc_width-1:0]     res1_pc;
  logic                             res1_taken;
  logic [bpu_pkg::pc_width-1:0]     res1_target;
  logic [bpu_pkg::jt_width-1:0]     res1_type;
} bp_row_t;

localparam logic [bpu_pkg::jt_width-1:0] jt_b = bpu_pkg::jt_branch;
localparam logic [bpu_pkg::jt_width-1:0] jt_c = bpu_pkg::jt_call;
localparam logic [bpu_pkg::jt_width-1:0] jt_r = bpu_pkg::jt_return;
localparam logic [bpu_pkg::jt_width-1:0] jt_j = bpu_pkg::jt_jump;

localparam int bp_row_count = 22;

// id, fv, pc, next_pc, valid, jump, then res0 and res1 as valid, pc, taken, target, type
localparam bp_row_t bp_rows [bp_row_count] = '{
  '{1, 1, 'h1000, 'h1010, 'hf, 'h0, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  '{1, 1, 'h1004, 'h1010, 'he, 'h0, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  '{1, 1, 'h1008, 'h1010, 'hc, 'h0, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  '{1, 1, 'h100c, 'h1010, 'h8, 'h0, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  // branch at slot 2 of group 0x2000, allocated weakly taken
  '{2, 1, 'h2000, 'h2010, 'hf, 'h0, 1, 'h2008, 1, 'h3000, jt_b, 0, 0, 0, 0, jt_b},
  '{2, 1, 'h2000, 'h3000, 'h7, 'h4, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  '{2, 1, 'h200c, 'h2010, 'h8, 'h0, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  // counter 2 -> 1 -> 0 -> 1 -> 2
  '{3, 1, 'h2000, 'h3000, 'h7, 'h4, 1, 'h2008, 0, 'h3000, jt_b, 0, 0, 0, 0, jt_b},
  '{3, 1, 'h2000, 'h2010, 'hf, 'h0, 1, 'h2008, 0, 'h3000, jt_b, 0, 0, 0, 0, jt_b},
  '{3, 1, 'h2000, 'h2010, 'hf, 'h0, 1, 'h2008, 1, 'h3000, jt_b, 0, 0, 0, 0, jt_b},
  '{3, 1, 'h2000, 'h2010, 'hf, 'h0, 1, 'h2008, 1, 'h3000, jt_b, 0, 0, 0, 0, jt_b},
  '{3, 1, 'h2000, 'h3000, 'h7, 'h4, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  // 0x4008 shares index 2 with a different tag
  '{4, 1, 'h4000, 'h4010, 'hf, 'h0, 1, 'h4008, 1, 'h5000, jt_b, 0, 0, 0, 0, jt_b},
  '{4, 1, 'h2000, 'h2010, 'hf, 'h0, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  '{4, 1, 'h4000, 'h5000, 'h7, 'h4, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  // call at 0x6004 pushes 0x6008, return entry at 0x700c
  '{5, 0, 'h7000, 'h7010, 'hf, 'h0, 1, 'h6004, 1, 'h7000, jt_c, 1, 'h700c, 1, 'h6008, jt_r},
  // no fetch here, so the stack keeps its entry
  '{5, 0, 'h700c, 'h6008, 'h8, 'h8, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  '{5, 1, 'h700c, 'h6008, 'h8, 'h8, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  '{5, 1, 'h700c, 'h7010, 'h8, 'h0, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  // both ports allocate, indices 0 and 5
  '{6, 1, 'h8000, 'h8010, 'hf, 'h0, 1, 'h8000, 1, 'h8800, jt_b, 1, 'ha014, 1, 'hb000, jt_j},
  '{6, 1, 'h8000, 'h8800, 'h1, 'h1, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b},
  '{6, 1, 'ha010, 'hb000, 'h3, 'h2, 0, 0, 0, 0, jt_b, 0, 0, 0, 0, jt_b}
};

`endif

// ==== sim/tb_branch_predictor.sv ====
// testbench for the branch predictor, applies the vector table row by row and checks each lookup
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

  `include "bp_vectors.svh"

  localparam int reset_cycles = 16;
  localparam int cycle_limit = reset_cycles + 4 * bp_row_count + 20;

  logic                            clk;
  logic                            reset;
  logic [bpu_pkg::pc_width-1:0]    pc;
  logic                            fetch_valid;
  logic [bpu_pkg::pc_width-1:0]    next_pc;
  logic [bpu_pkg::group_slots-1:0] pc_valid;
  logic [bpu_pkg::group_slots-1:0] pc_is_jump;
  logic                            res0_valid;
  logic [bpu_pkg::pc_width-1:0]    res0_pc;
  logic                            res0_taken;
  logic [bpu_pkg::pc_width-1:0]    res0_target;
  logic [bpu_pkg::jt_width-1:0]    res0_type;
  logic                            res1_valid;
  logic [bpu_pkg::pc_width-1:0]    res1_pc;
  logic                            res1_taken;
  logic [bpu_pkg::pc_width-1:0]    res1_target;
  logic [bpu_pkg::jt_width-1:0]    res1_type;

  int cycles;
  int tests_passed;
  int tests_failed;
  bit test_bad;

  branch_predictor #(
    .table_idx_bits(7),
    .ras_depth(8)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .fetch_valid(fetch_valid),
    .next_pc    (next_pc),
    .pc_valid   (pc_valid),
    .pc_is_jump (pc_is_jump),
    .res0_valid (res0_valid),
    .res0_pc    (res0_pc),
    .res0_taken (res0_taken),
    .res0_target(res0_target),
    .res0_type  (res0_type),
    .res1_valid (res1_valid),
    .res1_pc    (res1_pc),
    .res1_taken (res1_taken),
    .res1_target(res1_target),
    .res1_type  (res1_type)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // bounds the run in case the sequence stalls
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

  task automatic drive_row(input bp_row_t r);
    pc <= r.pc;
    fetch_valid <= r.fetch_valid;
    res0_valid <= r.res0_valid;
    res0_pc <= r.res0_pc;
    res0_taken <= r.res0_taken;
    res0_target <= r.res0_target;
    res0_type <= r.res0_type;
    res1_valid <= r.res1_valid;
    res1_pc <= r.res1_pc;
    res1_taken <= r.res1_taken;
    res1_target <= r.res1_target;
    res1_type <= r.res1_type;
  endtask

  task automatic check_outputs(input bp_row_t r);
    assert (next_pc === r.exp_next_pc) else begin
      $display("error next_pc pc %h expected %h got %h", r.pc, r.exp_next_pc, next_pc);
      test_bad = 1'b1;
    end
    assert (pc_valid === r.exp_pc_valid) else begin
      $display("error pc_valid pc %h expected %h got %h", r.pc, r.exp_pc_valid, pc_valid);
      test_bad = 1'b1;
    end
    assert (pc_is_jump === r.exp_pc_is_jump) else begin
      $display("error pc_is_jump pc %h expected %h got %h", r.pc, r.exp_pc_is_jump, pc_is_jump);
      test_bad = 1'b1;
    end
  endtask

  task automatic report_test(input int id);
    if (test_bad) begin
      tests_failed++;
      $display("test %0d failed", id);
    end else begin
      tests_passed++;
      $display("test %0d passed", id);
    end
    test_bad = 1'b0;
  endtask

  initial begin
    void'($urandom(9));
    tests_passed = 0;
    tests_failed = 0;
    test_bad = 1'b0;
    reset = 1'b1;
    pc = '0;
    fetch_valid = 1'b0;
    res0_valid = 1'b0;
    res0_pc = '0;
    res0_taken = 1'b0;
    res0_target = '0;
    res0_type = '0;
    res1_valid = 1'b0;
    res1_pc = '0;
    res1_taken = 1'b0;
    res1_target = '0;
    res1_type = '0;

    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    // each row is one cycle, outputs sampled at the falling edge
    for (int i = 0; i < bp_row_count; i++) begin
      @(posedge clk);
      drive_row(bp_rows[i]);
      @(negedge clk);
      if (i > 0 && bp_rows[i].test_id != bp_rows[i-1].test_id) begin
        report_test(bp_rows[i-1].test_id);
      end
      check_outputs(bp_rows[i]);
    end
    report_test(bp_rows[bp_row_count-1].test_id);

    @(posedge clk);
    res0_valid <= 1'b0;
    res1_valid <= 1'b0;
    fetch_valid <= 1'b0;
    @(posedge clk);

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
logic/bpu_pkg.sv
logic/branch_target_table.sv
logic/return_stack.sv
logic/fetch_group_select.sv
logic/branch_predictor.sv
sim/tb_branch_predictor.sv
